//--- Bender.yml
package:
  name: srl_fifo

sources:
  # package first, then the RTL bottom up
  - source/srl_fifo_pkg.sv
  - source/ndeep_srl.sv
  - source/fifo_write_ctrl.sv
  - source/fifo_read_ctrl.sv
  - source/srl_fifo_top.sv

  - target: simulation
    files:
      - sim/srl_fifo_properties.sv
      - sim/tb_srl_fifo.sv

//--- all.f
source/srl_fifo_pkg.sv
source/ndeep_srl.sv
source/fifo_write_ctrl.sv
source/fifo_read_ctrl.sv
source/srl_fifo_top.sv
sim/srl_fifo_properties.sv
sim/tb_srl_fifo.sv

//--- sim/srl_fifo_properties.sv
// protocol properties of the credit FIFO, checked from inside the top level
module srl_fifo_properties (
  input  logic                                CLK,
  input  logic                                rst_i,
  input  logic                                push_i,
  input  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] count_i,
  input  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] dcredit_i,
  input  logic                                out_valid_i,
  input  logic                                credit_ret_i
);

  // the upstream credits keep the sender from pushing into a full FIFO
  push_not_full: assert property (
    @(posedge CLK) disable iff (rst_i)
    !(push_i && (count_i == srl_fifo_pkg::DEPTH))
  ) else $error("push while the FIFO holds DEPTH entries");

  // a beat leaves only after a downstream credit was held at the popping edge
  out_needs_credit: assert property (
    @(posedge CLK) disable iff (rst_i)
    out_valid_i |-> ($past(dcredit_i) != '0)
  ) else $error("output beat without a downstream credit held");

  // credit return and output beat come from the same pop, so they travel together
  credit_with_beat: assert property (
    @(posedge CLK) disable iff (rst_i)
    credit_ret_i == out_valid_i
  ) else $error("credit_o and out_valid_o disagree");

  count_in_range: assert property (
    @(posedge CLK) disable iff (rst_i)
    count_i <= srl_fifo_pkg::DEPTH
  ) else $error("occupancy count above DEPTH");

endmodule

bind srl_fifo_top srl_fifo_properties srl_fifo_properties_inst (
  .CLK          (CLK),
  .rst_i        (rst_i),
  .push_i       (push),
  .count_i      (count),
  .dcredit_i    (fifo_read_ctrl_inst.dcredit_q),
  .out_valid_i  (out_valid_o),
  .credit_ret_i (credit_o)
);

//--- sim/tb_srl_fifo.sv
// table-driven testbench for the credit FIFO
// every phase sends a run of beats under upstream credits and grants the
// same number of downstream credits, then waits for the FIFO to drain
module tb_srl_fifo;

  typedef enum logic [1:0] {
    CREDIT_BURST,  // one downstream credit per cycle
    CREDIT_RANDOM, // credits granted on a coin flip
    CREDIT_NONE    // fill first with no credit, then grant a burst
  } credit_mode_e;

  typedef struct packed {
    int                                n_beats;
    logic [srl_fifo_pkg::DATA_WIDTH-1:0] first_data;
    logic [srl_fifo_pkg::DATA_WIDTH-1:0] step;
    int                                gap;     // idle cycles after each beat
    int                                pkt_len; // last is set on every pkt_len-th beat
    credit_mode_e                      credit_mode;
  } phase_t;

  localparam int NUM_PHASES = 5;

  phase_t phases [NUM_PHASES] = '{
    '{n_beats: 16, first_data: 8'h01, step: 8'h01, gap: 1, pkt_len: 4,
      credit_mode: CREDIT_BURST},
    '{n_beats: 32, first_data: 8'h80, step: 8'h03, gap: 0, pkt_len: 8,
      credit_mode: CREDIT_NONE},
    '{n_beats: 64, first_data: 8'h10, step: 8'h07, gap: 0, pkt_len: 5,
      credit_mode: CREDIT_RANDOM},
    '{n_beats: 12, first_data: 8'hf0, step: 8'h01, gap: 3, pkt_len: 3,
      credit_mode: CREDIT_BURST},
    '{n_beats: 48, first_data: 8'h55, step: 8'h0d, gap: 0, pkt_len: 16,
      credit_mode: CREDIT_RANDOM}
  };

  string phase_names [NUM_PHASES] = '{
    "basic_order",
    "fill_to_full",
    "push_pop_random",
    "sparse_input",
    "random_long"
  };

  logic                CLK = 1'b0;
  logic                rst_i;
  logic                in_valid_i;
  srl_fifo_pkg::beat_t in_beat_i;
  logic                credit_o;
  logic                credit_i;
  logic                out_valid_o;
  srl_fifo_pkg::beat_t out_beat_o;

  srl_fifo_pkg::beat_t expected_q [$]; // beats sent and not yet seen at the output

  int up_credit = srl_fifo_pkg::DEPTH; // sender side view of the upstream credits
  int tx_count = 0;
  int rx_count = 0;
  int granted_total = 0;
  int credit_pulses = 0;
  int mismatch_errors = 0;
  int other_errors = 0;
  int cur_phase = 0;
  int phase_sent;
  int phase_granted;
  int gap_left;
  int cycle_count = 0;
  int cycle_limit;
  int unused_seed;

  always #50 CLK = ~CLK;

  srl_fifo_top srl_fifo_top_inst (
    .CLK         (CLK),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_beat_i   (in_beat_i),
    .credit_o    (credit_o),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_beat_o  (out_beat_o)
  );

  function automatic int total_beats();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_PHASES; i++) begin
      sum += phases[i].n_beats;
    end
    return sum;
  endfunction

  // data counts up by the phase step, last closes each packet and the phase
  function automatic srl_fifo_pkg::beat_t make_beat(input int p, input int idx);
    srl_fifo_pkg::beat_t beat;
    beat.data = phases[p].first_data + phases[p].step * idx[srl_fifo_pkg::DATA_WIDTH-1:0];
    beat.last = ((idx % phases[p].pkt_len) == (phases[p].pkt_len - 1)) ||
                (idx == (phases[p].n_beats - 1));
    return beat;
  endfunction

  task automatic report_beat_mismatch(input srl_fifo_pkg::beat_t exp_beat,
                                      input srl_fifo_pkg::beat_t act_beat);
    mismatch_errors++;
    $display("mismatch in %s: expected data %h last %b, actual data %h last %b",
             phase_names[cur_phase], exp_beat.data, exp_beat.last,
             act_beat.data, act_beat.last);
  endtask

  task automatic report_count_mismatch(input string what, input int exp_val,
                                       input int act_val);
    mismatch_errors++;
    $display("mismatch in %s: %s expected %0d, actual %0d",
             phase_names[cur_phase], what, exp_val, act_val);
  endtask

  task automatic report_failure(input string msg);
    other_errors++;
    $display("error in %s at cycle %0d: %s", phase_names[cur_phase], cycle_count, msg);
  endtask

  // compares one output beat against the oldest beat still expected
  task automatic check_output_beat();
    srl_fifo_pkg::beat_t exp_beat;
    rx_count++;
    assert (expected_q.size() != 0)
      else report_failure("output beat appeared with no beat left to expect");
    if (expected_q.size() != 0) begin
      exp_beat = expected_q.pop_front();
      assert (out_beat_o == exp_beat) else report_beat_mismatch(exp_beat, out_beat_o);
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge CLK) begin
    if (!rst_i) begin
      if (credit_o) begin
        credit_pulses++;
        up_credit++;
        assert (up_credit <= srl_fifo_pkg::DEPTH)
          else report_failure("credit_o returned more credits than were spent");
      end
      if (out_valid_o) begin
        check_output_beat();
      end
      assert (rx_count <= granted_total)
        else report_failure("more output beats than downstream credits granted");
    end
  end

  // one clock of stimulus, a beat if the sender may send and a credit if allowed
  task automatic drive_cycle(input int p, input bit allow_credit);
    srl_fifo_pkg::beat_t beat;
    bit send;
    bit grant;
    send = 1'b0;
    grant = 1'b0;
    @(posedge CLK);
    if (phase_sent < phases[p].n_beats && gap_left == 0 && up_credit > 0) begin
      send = 1'b1;
    end else if (gap_left > 0) begin
      gap_left--;
    end
    if (send) begin
      beat = make_beat(p, phase_sent);
      in_valid_i <= 1'b1;
      in_beat_i  <= beat;
      expected_q.push_back(beat);
      up_credit--; // never reached with zero credits
      phase_sent++;
      tx_count++;
      gap_left = phases[p].gap;
    end else begin
      in_valid_i <= 1'b0;
    end
    if (allow_credit && phase_granted < phases[p].n_beats) begin
      if (phases[p].credit_mode == CREDIT_RANDOM) begin
        grant = ($urandom % 2) == 0;
      end else begin
        grant = 1'b1;
      end
    end
    credit_i <= grant;
    if (grant) begin
      phase_granted++;
      granted_total++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      in_valid_i <= 1'b0;
      credit_i   <= 1'b0;
    end
  endtask

  // with no downstream credit nothing may leave and no credit may come back
  task automatic check_full_hold(input int p, input int rx_start, input int pulses_start);
    assert (up_credit == srl_fifo_pkg::DEPTH - phases[p].n_beats)
      else report_count_mismatch("upstream credit while full",
                                 srl_fifo_pkg::DEPTH - phases[p].n_beats, up_credit);
    assert (rx_count == rx_start)
      else report_count_mismatch("output beats without credit", 0, rx_count - rx_start);
    assert (credit_pulses == pulses_start)
      else report_count_mismatch("credit_o pulses without credit", 0,
                                 credit_pulses - pulses_start);
  endtask

  task automatic run_phase(input int p);
    int rx_start;
    int pulses_start;
    cur_phase = p;
    phase_sent = 0;
    phase_granted = 0;
    gap_left = 0;
    rx_start = rx_count;
    pulses_start = credit_pulses;

    if (phases[p].credit_mode == CREDIT_NONE) begin
      while (phase_sent < phases[p].n_beats) begin
        drive_cycle(p, 1'b0);
      end
      idle_cycles(4); // lets the last beat reach the columns
      check_full_hold(p, rx_start, pulses_start);
    end

    while (phase_sent < phases[p].n_beats || phase_granted < phases[p].n_beats) begin
      drive_cycle(p, 1'b1);
    end

    // drain, then the credit returns must balance the beats received
    idle_cycles(1);
    while (rx_count != tx_count) begin
      idle_cycles(1);
    end
    idle_cycles(2);
    assert (credit_pulses - pulses_start == rx_count - rx_start)
      else report_count_mismatch("credit_o pulses against beats received",
                                 rx_count - rx_start, credit_pulses - pulses_start);
    assert (up_credit == srl_fifo_pkg::DEPTH)
      else report_count_mismatch("upstream credit after drain",
                                 srl_fifo_pkg::DEPTH, up_credit);
    assert (expected_q.size() == 0)
      else report_count_mismatch("beats left unreceived", 0, expected_q.size());
  endtask

  // watchdog, generous for the slowest gap and random credit mix
  initial begin
    cycle_limit = total_beats() * 8 + 200;
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    unused_seed = $urandom(16400);
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    in_beat_i  = '0;
    credit_i   = 1'b0;

    repeat (4) @(posedge CLK);
    rst_i <= 1'b0;
    idle_cycles(2);

    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(p);
    end

    $display("errors: %0d mismatches, %0d other, %0d beats checked",
             mismatch_errors, other_errors, rx_count);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- source/fifo_read_ctrl.sv
// read side of the FIFO
// downstream hands out credits one pulse at a time, and the FIFO spends
// one of them on every beat it emits
module fifo_read_ctrl (
  input  logic                                CLK,
  input  logic                                rst_i,
  input  logic                                credit_i,
  input  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] count_i,
  input  srl_fifo_pkg::beat_t                 head_beat_i,
  output logic                                pop_o,
  output logic                                out_valid_o,
  output srl_fifo_pkg::beat_t                 out_beat_o
);

  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] dcredit_q; // downstream credits held
  logic                                pop;
  logic                                out_valid_q;
  srl_fifo_pkg::beat_t                 out_beat_q;

  // pop needs something stored and something to spend
  assign pop = (count_i != '0) && (dcredit_q != '0);

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      dcredit_q   <= '0;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= pop; // one output cycle per popped entry

      // a credit arriving in the same cycle as a pop replaces the one spent
      case ({credit_i, pop})
        2'b10:   dcredit_q <= dcredit_q + 1'b1;
        2'b01:   dcredit_q <= dcredit_q - 1'b1;
        default: dcredit_q <= dcredit_q;
      endcase
    end
  end

  // the head tap is captured at the popping edge, before the columns
  // settle to the next address
  always_ff @(posedge CLK) begin
    if (pop) begin
      out_beat_q <= head_beat_i;
    end
  end

  assign pop_o       = pop;
  assign out_valid_o = out_valid_q;
  assign out_beat_o  = out_beat_q;

endmodule

//--- source/fifo_write_ctrl.sv
// write side of the FIFO
// the incoming beat is registered first and pushed into the columns one cycle
// later, which keeps the input path short and gives the storage a clean enable
module fifo_write_ctrl (
  input  logic                                CLK,
  input  logic                                rst_i,
  input  logic                                in_valid_i,
  input  srl_fifo_pkg::beat_t                 in_beat_i,
  input  logic                                pop_i,
  output logic                                push_o,
  output srl_fifo_pkg::beat_t                 push_beat_o,
  output logic [srl_fifo_pkg::ADDR_WIDTH-1:0]  addr_o,
  output logic [srl_fifo_pkg::COUNT_WIDTH-1:0] count_o,
  output logic                                credit_o
);

  logic                                push_q;
  srl_fifo_pkg::beat_t                 beat_q;
  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] count_q;
  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] count_m1;
  logic                                credit_q;

  // control state
  always_ff @(posedge CLK) begin
    if (rst_i) begin
      push_q   <= 1'b0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      push_q   <= in_valid_i; // becomes the shift enable of all columns
      credit_q <= pop_i;      // one credit back upstream per freed entry

      // occupancy follows push and pop, both at once leaves it alone
      case ({push_q, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload register, only loaded when a beat actually arrives
  always_ff @(posedge CLK) begin
    if (in_valid_i) begin
      beat_q <= in_beat_i;
    end
  end

  // the oldest entry sits at position count-1
  // a push together with a pop moves it one deeper, but the popped entry
  // leaves at the same edge, so the same address names the next oldest one
  assign count_m1 = count_q - 1'b1;

  // with an empty FIFO this wraps to DEPTH-1, the read side ignores it then
  assign addr_o = count_m1[srl_fifo_pkg::ADDR_WIDTH-1:0];

  assign push_o      = push_q;
  assign push_beat_o = beat_q;
  assign count_o     = count_q;
  assign credit_o    = credit_q;

endmodule

//--- source/ndeep_srl.sv
// one bit of every stored beat lives here
// new bits enter at position 0 and older ones move toward DEPTH-1,
// so the oldest entry is always at the highest occupied position
module ndeep_srl (
  input  logic                              CLK,
  input  logic                              shift_en_i,
  input  logic [srl_fifo_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic                              bit_i,
  output logic                              bit_o
);

  logic [srl_fifo_pkg::DEPTH-1:0] shift_reg; // contents are not reset

  // plain shift with a clock enable so synthesis can map it onto an SRL
  always_ff @(posedge CLK) begin
    if (shift_en_i) begin
      shift_reg <= {shift_reg[srl_fifo_pkg::DEPTH-2:0], bit_i};
    end
  end

  // the tap is a pure mux, the read side sees the addressed bit in the same cycle
  assign bit_o = shift_reg[addr_i];

endmodule

//--- source/srl_fifo_pkg.sv
package srl_fifo_pkg;

  // payload is one byte of data plus the end-of-packet flag
  localparam int DATA_WIDTH = 8;

  // one storage column per beat bit
  localparam int BEAT_WIDTH = DATA_WIDTH + 1;

  // tap address into a single shift-register column
  localparam int ADDR_WIDTH = 5;

  localparam int DEPTH = 2 ** ADDR_WIDTH; // entries per column

  // one extra bit so the counters can hold a full FIFO, 0 through DEPTH
  localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

  // a stream beat as it crosses the ports and the storage
  // last sits in bit 0 and data above it, so column 0 stores the flag
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } beat_t;

endpackage

//--- source/srl_fifo_top.sv
// credit-controlled FIFO built from one shift-register column per beat bit
// all columns share one shift enable and one tap address, so together they
// behave as a single BEAT_WIDTH wide shift register
module srl_fifo_top (
  input  logic                CLK,
  input  logic                rst_i,
  input  logic                in_valid_i,
  input  srl_fifo_pkg::beat_t in_beat_i,
  output logic                credit_o,
  input  logic                credit_i,
  output logic                out_valid_o,
  output srl_fifo_pkg::beat_t out_beat_o
);

  logic                                push;
  srl_fifo_pkg::beat_t                 push_beat;
  logic [srl_fifo_pkg::ADDR_WIDTH-1:0]  addr;
  logic [srl_fifo_pkg::COUNT_WIDTH-1:0] count;
  logic                                pop;
  srl_fifo_pkg::beat_t                 head_beat;

  // flat views of the beat for the per-bit columns
  logic [srl_fifo_pkg::BEAT_WIDTH-1:0] push_bits;
  logic [srl_fifo_pkg::BEAT_WIDTH-1:0] head_bits;

  assign push_bits = push_beat;
  assign head_beat = head_bits;

  fifo_write_ctrl fifo_write_ctrl_inst (
    .CLK         (CLK),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_beat_i   (in_beat_i),
    .pop_i       (pop),
    .push_o      (push),
    .push_beat_o (push_beat),
    .addr_o      (addr),
    .count_o     (count),
    .credit_o    (credit_o)
  );

  for (genvar i = 0; i < srl_fifo_pkg::BEAT_WIDTH; i++) begin : gen_columns
    ndeep_srl ndeep_srl_inst (
      .CLK        (CLK),
      .shift_en_i (push),
      .addr_i     (addr),
      .bit_i      (push_bits[i]),
      .bit_o      (head_bits[i])
    );
  end

  fifo_read_ctrl fifo_read_ctrl_inst (
    .CLK         (CLK),
    .rst_i       (rst_i),
    .credit_i    (credit_i),
    .count_i     (count),
    .head_beat_i (head_beat),
    .pop_o       (pop),
    .out_valid_o (out_valid_o),
    .out_beat_o  (out_beat_o)
  );

endmodule
